//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_dual_exec_core
FILELIST = all.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

//--- all.f
hw/core_pkg.sv
hw/instr_decode.sv
hw/regfile.sv
hw/alu.sv
hw/commit.sv
hw/dual_exec_core.sv
verif/tb_dual_exec_core.sv

//--- hw/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
    input  decode_t      dec,
    input  word_t        opa,
    input  word_t        opb,
    input  addr_t        pc,
    output lane_result_t res
);

    word_t imm_ext;
    word_t b;

    assign imm_ext = dec.zero_ext ? {16'h0000, dec.imm} : {{16{dec.imm[15]}}, dec.imm};
    assign b       = dec.use_imm ? imm_ext : opb;

    always_comb begin
        res.pc  = pc;
        res.dst = dec.dst;
        res.wen = dec.wen;
        case (dec.op)
            ALU_ADD: res.value = opa + b;
            ALU_SUB: res.value = opa - b;
            ALU_AND: res.value = opa & b;
            ALU_OR:  res.value = opa | b;
            ALU_XOR: res.value = opa ^ b;
            ALU_SLT: res.value = {31'h0, $signed(opa) < $signed(b)};
            ALU_SLL: res.value = b << dec.shamt; // shifts act on rt.
            ALU_SRL: res.value = b >> dec.shamt;
            ALU_LUI: res.value = {dec.imm, 16'h0000};
            default: res.value = '0;
        endcase
    end

endmodule

//--- hw/commit.sv
`timescale 1ns/1ps

module commit import core_pkg::*; (
    input  lane_result_t r1,
    input  lane_result_t r2,
    input  logic         fire,
    output logic         we1,
    output logic         we2,
    output regid_t       wa1,
    output regid_t       wa2,
    output word_t        wd1,
    output word_t        wd2,
    output debug_wb_t    dbg_wb1,
    output debug_wb_t    dbg_wb2
);

    logic shadowed;

    assign we1 = fire & r1.wen;
    assign we2 = fire & r2.wen;
    assign wa1 = r1.dst;
    assign wa2 = r2.dst;
    assign wd1 = r1.value;
    assign wd2 = r2.value;

    // lane 1's write is lost when lane 2 targets the same register.
    assign shadowed = we2 && (r2.dst == r1.dst);

    always_comb begin
        dbg_wb1.pc       = r1.pc;
        dbg_wb1.rf_wen   = we1 & ~shadowed;
        dbg_wb1.rf_wnum  = r1.dst;
        dbg_wb1.rf_wdata = r1.value;
        dbg_wb2.pc       = r2.pc;
        dbg_wb2.rf_wen   = we2;
        dbg_wb2.rf_wnum  = r2.dst;
        dbg_wb2.rf_wdata = r2.value;
    end

endmodule

//--- hw/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  regid_t;

    // opcodes use the MIPS encoding.
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // funct codes for R-type.
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef struct packed {
        logic [5:0] opcode;
        regid_t     rs;
        regid_t     rt;
        regid_t     rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        regid_t      rs;
        regid_t      rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_NOP
    } alu_op_t;

    typedef struct packed {
        regid_t      src1;
        regid_t      src2;
        regid_t      dst;
        alu_op_t     op;
        logic        use_imm;
        logic        zero_ext;
        logic [15:0] imm;
        logic [4:0]  shamt;
        logic        wen;
    } decode_t;

    typedef struct packed {
        addr_t  pc;
        instr_t instr;
        logic   valid;
    } issue_lane_t;

    typedef struct packed {
        issue_lane_t lane1;
        issue_lane_t lane2;
    } issue_pkt_t;

    typedef struct packed {
        addr_t  pc;
        regid_t dst;
        logic   wen;
        word_t  value;
    } lane_result_t;

    typedef struct packed {
        addr_t  pc;
        logic   rf_wen;
        regid_t rf_wnum;
        word_t  rf_wdata;
    } debug_wb_t;

endpackage

//--- hw/dual_exec_core.sv
`timescale 1ns/1ps

module dual_exec_core import core_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       req,
    input  issue_pkt_t pkt,
    output logic       ack,
    output debug_wb_t  dbg_wb1,
    output debug_wb_t  dbg_wb2
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_DECODE,
        S_EXEC,
        S_COMMIT,
        S_WAIT_REL
    } state_t;

    state_t       state;
    issue_pkt_t   pkt_q;
    decode_t      dec1, dec2;
    decode_t      dec1_q, dec2_q;
    word_t        rd1, rd2, rd3, rd4;
    word_t        opa1_q, opb1_q, opa2_q, opb2_q;
    addr_t        pc1_q, pc2_q;
    lane_result_t res1, res2;
    lane_result_t res1_q, res2_q;
    logic         fire;
    logic         we1, we2;
    regid_t       wa1, wa2;
    word_t        wd1, wd2;
    debug_wb_t    wb1, wb2;

    instr_decode u_dec1 (.instr(pkt_q.lane1.instr), .dec(dec1));
    instr_decode u_dec2 (.instr(pkt_q.lane2.instr), .dec(dec2));

    regfile u_rf (
        .clk(clk), .resetn(resetn),
        .ra1(dec1.src1), .ra2(dec1.src2), .ra3(dec2.src1), .ra4(dec2.src2),
        .rd1(rd1), .rd2(rd2), .rd3(rd3), .rd4(rd4),
        .we1(we1), .we2(we2), .wa1(wa1), .wa2(wa2), .wd1(wd1), .wd2(wd2)
    );

    alu u_alu1 (.dec(dec1_q), .opa(opa1_q), .opb(opb1_q), .pc(pc1_q), .res(res1));
    alu u_alu2 (.dec(dec2_q), .opa(opa2_q), .opb(opb2_q), .pc(pc2_q), .res(res2));

    assign fire = (state == S_COMMIT); // one write slot per packet.

    commit u_commit (
        .r1(res1_q), .r2(res2_q), .fire(fire),
        .we1(we1), .we2(we2), .wa1(wa1), .wa2(wa2), .wd1(wd1), .wd2(wd2),
        .dbg_wb1(wb1), .dbg_wb2(wb2)
    );

    // handshake FSM and debug records.
    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= S_IDLE;
            ack     <= 1'b0;
            dbg_wb1 <= '0;
            dbg_wb2 <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req && !ack) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: state <= S_EXEC;
                S_EXEC:   state <= S_COMMIT;
                S_COMMIT: begin
                    state   <= S_WAIT_REL;
                    ack     <= 1'b1; // rises with the regfile write.
                    dbg_wb1 <= wb1;
                    dbg_wb2 <= wb2;
                end
                S_WAIT_REL: begin
                    if (!req) begin
                        state <= S_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // pipeline payload.
    always_ff @(posedge clk) begin
        if (state == S_IDLE && req && !ack) begin
            pkt_q <= pkt;
        end
        if (state == S_DECODE) begin
            dec1_q     <= dec1;
            dec1_q.wen <= dec1.wen & pkt_q.lane1.valid; // invalid lanes write nothing.
            dec2_q     <= dec2;
            dec2_q.wen <= dec2.wen & pkt_q.lane2.valid;
            opa1_q     <= rd1;
            opb1_q     <= rd2;
            opa2_q     <= rd3;
            opb2_q     <= rd4;
            pc1_q      <= pkt_q.lane1.pc;
            pc2_q      <= pkt_q.lane2.pc;
        end
        if (state == S_EXEC) begin
            res1_q <= res1;
            res2_q <= res2;
        end
    end

endmodule

//--- hw/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import core_pkg::*; (
    input  instr_t  instr,
    output decode_t dec
);

    logic known;

    always_comb begin
        dec       = '0;
        known     = 1'b1;
        dec.src1  = instr.r.rs;
        dec.src2  = instr.r.rt;
        dec.imm   = instr.i.imm;
        dec.shamt = instr.r.shamt;
        dec.op    = ALU_NOP;
        if (instr.r.opcode == OP_RTYPE) begin
            dec.dst = instr.r.rd;
            case (instr.r.funct)
                FN_ADD:  dec.op = ALU_ADD;
                FN_SUB:  dec.op = ALU_SUB;
                FN_AND:  dec.op = ALU_AND;
                FN_OR:   dec.op = ALU_OR;
                FN_XOR:  dec.op = ALU_XOR;
                FN_SLT:  dec.op = ALU_SLT;
                FN_SLL:  dec.op = ALU_SLL;
                FN_SRL:  dec.op = ALU_SRL;
                default: known = 1'b0;
            endcase
        end else begin
            dec.dst     = instr.i.rt; // I-type writes rt.
            dec.use_imm = 1'b1;
            case (instr.i.opcode)
                OP_ADDI: dec.op = ALU_ADD;
                OP_ANDI: begin
                    dec.op       = ALU_AND;
                    dec.zero_ext = 1'b1; // logical immediates are zero extended.
                end
                OP_ORI: begin
                    dec.op       = ALU_OR;
                    dec.zero_ext = 1'b1;
                end
                OP_XORI: begin
                    dec.op       = ALU_XOR;
                    dec.zero_ext = 1'b1;
                end
                OP_LUI:  dec.op = ALU_LUI;
                default: known = 1'b0;
            endcase
        end
        dec.wen = known && (dec.dst != '0); // r0 is never written.
    end

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ps

module regfile import core_pkg::*; (
    input  logic   clk,
    input  logic   resetn,
    input  regid_t ra1,
    input  regid_t ra2,
    input  regid_t ra3,
    input  regid_t ra4,
    output word_t  rd1,
    output word_t  rd2,
    output word_t  rd3,
    output word_t  rd4,
    input  logic   we1,
    input  logic   we2,
    input  regid_t wa1,
    input  regid_t wa2,
    input  word_t  wd1,
    input  word_t  wd2
);

    word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1 && wa1 != '0) begin
                regs[wa1] <= wd1;
            end
            if (we2 && wa2 != '0) begin
                regs[wa2] <= wd2; // last assignment wins, so port 2 has priority.
            end
        end
    end

    // reads see the state before this cycle's writes.
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];
    assign rd3 = (ra3 == '0) ? '0 : regs[ra3];
    assign rd4 = (ra4 == '0) ? '0 : regs[ra4];

endmodule

//--- verif/tb_dual_exec_core.sv
`timescale 1ns/1ps

module tb_dual_exec_core import core_pkg::*; ();

    localparam int N_RAND = 64;

    logic       clk;
    logic       resetn;
    logic       req;
    issue_pkt_t pkt;
    logic       ack;
    debug_wb_t  dbg_wb1;
    debug_wb_t  dbg_wb2;

    issue_pkt_t  dir_pkt [$];
    debug_wb_t   dir_e1 [$];
    debug_wb_t   dir_e2 [$];
    word_t       ref_regs [0:31];
    logic [31:0] seed = 32'hfb35;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    dual_exec_core DUT (
        .clk(clk), .resetn(resetn), .req(req), .pkt(pkt),
        .ack(ack), .dbg_wb1(dbg_wb1), .dbg_wb2(dbg_wb2)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("run timed out waiting for ack after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic instr_t rtype(input logic [5:0] fn, input int rs, input int rt,
                                     input int rd, input int sh);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic instr_t itype(input logic [5:0] op, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic issue_lane_t issue_lane(input addr_t pc, input instr_t ins,
                                               input logic valid);
        return '{pc, ins, valid};
    endfunction

    function automatic debug_wb_t wb_record(input addr_t pc, input logic wen, input int num,
                                            input word_t data);
        return '{pc, wen, num[4:0], data};
    endfunction

    task automatic add_directed(input issue_lane_t l1, input issue_lane_t l2,
                                input debug_wb_t e1, input debug_wb_t e2);
        dir_pkt.push_back('{l1, l2});
        dir_e1.push_back(e1);
        dir_e2.push_back(e2);
    endtask

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic instr_t rand_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [5:0]  op;
        logic [5:0]  fn;
        r = lcg_next();
        s = lcg_next();
        case (r[31:29]) // the upper bits pick the opcode because the low LCG bits repeat quickly.
            3'd0, 3'd1: op = OP_RTYPE;
            3'd2:       op = OP_ADDI;
            3'd3:       op = OP_ANDI;
            3'd4:       op = OP_ORI;
            3'd5:       op = OP_XORI;
            3'd6:       op = OP_LUI;
            default:    op = 6'h2b;
        endcase
        case (r[28:26])
            3'd0:    fn = FN_ADD;
            3'd1:    fn = FN_SUB;
            3'd2:    fn = FN_AND;
            3'd3:    fn = FN_OR;
            3'd4:    fn = FN_XOR;
            3'd5:    fn = FN_SLT;
            3'd6:    fn = FN_SLL;
            default: fn = FN_SRL;
        endcase
        if (op == OP_RTYPE) begin
            return rtype(fn, int'(r[25:23]), int'(r[22:20]), int'(r[19:17]), int'(r[16:12]));
        end
        return itype(op, int'(r[25:23]), int'(r[22:20]), s[31:16]);
    endfunction

    // computes what one lane does to the reference registers from the state before its packet.
    function automatic debug_wb_t lane_effect(input issue_lane_t l);
        debug_wb_t   w;
        logic        known;
        word_t       a;
        word_t       b;
        logic [15:0] imm;
        w     = '0;
        w.pc  = l.pc;
        known = 1'b1;
        a     = ref_regs[l.instr[25:21]];
        b     = ref_regs[l.instr[20:16]];
        imm   = l.instr[15:0];
        if (l.instr[31:26] == OP_RTYPE) begin
            w.rf_wnum = l.instr[15:11];
            case (l.instr[5:0])
                FN_ADD:  w.rf_wdata = a + b;
                FN_SUB:  w.rf_wdata = a - b;
                FN_AND:  w.rf_wdata = a & b;
                FN_OR:   w.rf_wdata = a | b;
                FN_XOR:  w.rf_wdata = a ^ b;
                FN_SLT:  w.rf_wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLL:  w.rf_wdata = b << l.instr[10:6];
                FN_SRL:  w.rf_wdata = b >> l.instr[10:6];
                default: known = 1'b0;
            endcase
        end else begin
            w.rf_wnum = l.instr[20:16];
            case (l.instr[31:26])
                OP_ADDI: w.rf_wdata = a + {{16{imm[15]}}, imm};
                OP_ANDI: w.rf_wdata = a & {16'h0000, imm};
                OP_ORI:  w.rf_wdata = a | {16'h0000, imm};
                OP_XORI: w.rf_wdata = a ^ {16'h0000, imm};
                OP_LUI:  w.rf_wdata = {imm, 16'h0000};
                default: known = 1'b0;
            endcase
        end
        w.rf_wen = known && l.valid && (w.rf_wnum != 5'd0);
        return w;
    endfunction

    task automatic predict_packet(input issue_pkt_t p, output debug_wb_t e1,
                                  output debug_wb_t e2);
        e1 = lane_effect(p.lane1);
        e2 = lane_effect(p.lane2);
        if (e2.rf_wen && e2.rf_wnum == e1.rf_wnum) begin
            e1.rf_wen = 1'b0; // lane 2 overwrites it.
        end
        if (e1.rf_wen) begin
            ref_regs[e1.rf_wnum] = e1.rf_wdata;
        end
        if (e2.rf_wen) begin
            ref_regs[e2.rf_wnum] = e2.rf_wdata;
        end
    endtask

    task automatic check_wb(input debug_wb_t got, input debug_wb_t exp, input string what);
        checks++;
        if (got.pc !== exp.pc || got.rf_wen !== exp.rf_wen || (exp.rf_wen &&
            (got.rf_wnum !== exp.rf_wnum || got.rf_wdata !== exp.rf_wdata))) begin
            errors++;
            $display("[ERROR] %0t: %s got pc=%h wen=%b r%0d=%h, expected pc=%h wen=%b r%0d=%h",
                     $time, what, got.pc, got.rf_wen, got.rf_wnum, got.rf_wdata,
                     exp.pc, exp.rf_wen, exp.rf_wnum, exp.rf_wdata);
        end
    endtask

    task automatic check_ack(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got ack=%b, expected %b", $time, what, got, exp);
        end
    endtask

    // runs the full four-phase exchange and starts and ends on a falling edge.
    task automatic run_packet(input issue_pkt_t p, input int hold,
                              output debug_wb_t got1, output debug_wb_t got2);
        int lat;
        pkt = p;
        req = 1'b1;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            check_ack(ack, lat >= 4, "ack rise timing"); // rises on the third edge after capture.
        end while (ack !== 1'b1);
        got1 = dbg_wb1;
        got2 = dbg_wb2;
        repeat (hold) begin
            @(negedge clk);
            check_ack(ack, 1'b1, "ack while req held high");
        end
        req = 1'b0;
        @(negedge clk);
        check_ack(ack, 1'b0, "ack release");
        while (ack !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        issue_pkt_t p;
        debug_wb_t  e1;
        debug_wb_t  e2;
        debug_wb_t  got1;
        debug_wb_t  got2;
        addr_t      pc;
        logic [31:0] v;
        resetn = 1'b1;
        req    = 1'b0;
        pkt    = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        add_directed(issue_lane(32'h100, itype(OP_ADDI, 0, 1, 16'h0005), 1'b1),
                     issue_lane(32'h104, itype(OP_ADDI, 0, 2, 16'hfffd), 1'b1),
                     wb_record(32'h100, 1'b1, 1, 32'h0000_0005),
                     wb_record(32'h104, 1'b1, 2, 32'hffff_fffd));
        add_directed(issue_lane(32'h108, rtype(FN_ADD, 1, 2, 3, 0), 1'b1),
                     issue_lane(32'h10c, rtype(FN_SUB, 1, 2, 4, 0), 1'b1),
                     wb_record(32'h108, 1'b1, 3, 32'h0000_0002),
                     wb_record(32'h10c, 1'b1, 4, 32'h0000_0008));
        add_directed(issue_lane(32'h110, rtype(FN_AND, 2, 1, 5, 0), 1'b1),
                     issue_lane(32'h114, rtype(FN_OR, 2, 3, 6, 0), 1'b1),
                     wb_record(32'h110, 1'b1, 5, 32'h0000_0005),
                     wb_record(32'h114, 1'b1, 6, 32'hffff_ffff));
        add_directed(issue_lane(32'h118, rtype(FN_XOR, 2, 4, 7, 0), 1'b1),
                     issue_lane(32'h11c, rtype(FN_SLT, 2, 1, 8, 0), 1'b1),
                     wb_record(32'h118, 1'b1, 7, 32'hffff_fff5),
                     wb_record(32'h11c, 1'b1, 8, 32'h0000_0001));
        add_directed(issue_lane(32'h120, rtype(FN_SLL, 0, 1, 9, 4), 1'b1),
                     issue_lane(32'h124, rtype(FN_SRL, 0, 2, 10, 28), 1'b1),
                     wb_record(32'h120, 1'b1, 9, 32'h0000_0050),
                     wb_record(32'h124, 1'b1, 10, 32'h0000_000f));
        add_directed(issue_lane(32'h128, itype(OP_ANDI, 2, 11, 16'h8001), 1'b1),
                     issue_lane(32'h12c, itype(OP_ORI, 1, 12, 16'h8000), 1'b1),
                     wb_record(32'h128, 1'b1, 11, 32'h0000_8001),
                     wb_record(32'h12c, 1'b1, 12, 32'h0000_8005));
        add_directed(issue_lane(32'h130, itype(OP_XORI, 2, 13, 16'hffff), 1'b1),
                     issue_lane(32'h134, itype(OP_LUI, 0, 14, 16'h1234), 1'b1),
                     wb_record(32'h130, 1'b1, 13, 32'hffff_0002),
                     wb_record(32'h134, 1'b1, 14, 32'h1234_0000));
        // lane 2 reads r1 before lane 1 updates it.
        add_directed(issue_lane(32'h138, itype(OP_ADDI, 1, 1, 16'h0001), 1'b1),
                     issue_lane(32'h13c, rtype(FN_ADD, 1, 0, 15, 0), 1'b1),
                     wb_record(32'h138, 1'b1, 1, 32'h0000_0006),
                     wb_record(32'h13c, 1'b1, 15, 32'h0000_0005));
        add_directed(issue_lane(32'h140, itype(OP_ADDI, 0, 3, 16'h0011), 1'b1),
                     issue_lane(32'h144, itype(OP_ADDI, 0, 3, 16'h0022), 1'b1),
                     wb_record(32'h140, 1'b0, 3, 32'h0000_0011),
                     wb_record(32'h144, 1'b1, 3, 32'h0000_0022));
        add_directed(issue_lane(32'h148, rtype(FN_ADD, 3, 0, 16, 0), 1'b1),
                     issue_lane(32'h14c, rtype(FN_SLT, 0, 2, 17, 0), 1'b1),
                     wb_record(32'h148, 1'b1, 16, 32'h0000_0022),
                     wb_record(32'h14c, 1'b1, 17, 32'h0000_0000));
        add_directed(issue_lane(32'h150, itype(OP_ADDI, 1, 0, 16'h0007), 1'b1),
                     issue_lane(32'h154, itype(6'h3f, 0, 1, 16'h0009), 1'b1),
                     wb_record(32'h150, 1'b0, 0, 32'h0),
                     wb_record(32'h154, 1'b0, 1, 32'h0));
        add_directed(issue_lane(32'h158, rtype(6'h3f, 1, 1, 2, 0), 1'b1),
                     issue_lane(32'h15c, itype(OP_ADDI, 0, 4, 16'h0077), 1'b0),
                     wb_record(32'h158, 1'b0, 2, 32'h0),
                     wb_record(32'h15c, 1'b0, 4, 32'h0));
        add_directed(issue_lane(32'h160, rtype(FN_ADD, 2, 0, 18, 0), 1'b1),
                     issue_lane(32'h164, rtype(FN_ADD, 4, 1, 19, 0), 1'b1),
                     wb_record(32'h160, 1'b1, 18, 32'hffff_fffd),
                     wb_record(32'h164, 1'b1, 19, 32'h0000_000e));
        cycle_limit = (dir_pkt.size() + N_RAND) * 8 + 20;

        repeat (2) @(negedge clk);
        resetn = 1'b0;
        check_ack(ack, 1'b0, "ack after reset");
        check_wb(dbg_wb1, '0, "lane 1 record after reset");
        check_wb(dbg_wb2, '0, "lane 2 record after reset");

        // a second capture of packet 7 would bump r1 again and show up in packet 12.
        foreach (dir_pkt[i]) begin
            run_packet(dir_pkt[i], (i == 7) ? 3 : 0, got1, got2);
            predict_packet(dir_pkt[i], e1, e2);
            check_wb(got1, dir_e1[i], $sformatf("directed %0d lane 1", i));
            check_wb(got2, dir_e2[i], $sformatf("directed %0d lane 2", i));
        end

        pc = 32'h1000;
        for (int n = 0; n < N_RAND; n++) begin
            v = lcg_next();
            p.lane1 = issue_lane(pc, rand_instr(), v[31:29] != 3'd0);
            p.lane2 = issue_lane(pc + 32'd4, rand_instr(), v[28:26] != 3'd0);
            pc = pc + 32'd8;
            run_packet(p, 0, got1, got2);
            predict_packet(p, e1, e2);
            check_wb(got1, e1, $sformatf("random %0d lane 1", n));
            check_wb(got2, e2, $sformatf("random %0d lane 2", n));
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
